//--- Makefile
# Verilator build and run of the FIX parser testbench

TOP = fix_parser_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f tb.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- rtl/fix_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// register block for the FIX parser
// enable and watched tag, field and match counters, read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_cfg_regs import fix_pkg::*; (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 cfg_we_i,
	input  fix_cfg_addr_t        cfg_addr_i,
	input  logic [31:0]          cfg_wdata_i,
	output logic [31:0]          cfg_rdata_o,
	input  fix_field_t           field_i,
	input  logic                 field_valid_i,
	output logic                 enable_o,
	output logic [FIX_TAG_W-1:0] watch_tag_o
);

	logic                 enable_q;
	logic [FIX_TAG_W-1:0] watch_q;
	logic [FIX_CNT_W-1:0] field_cnt_q;
	logic [FIX_CNT_W-1:0] match_cnt_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			enable_q    <= 1'b0;
			watch_q     <= '0;
			field_cnt_q <= '0;
			match_cnt_q <= '0;
		end else begin
			if (cfg_we_i && cfg_addr_i == CFG_CTRL) begin
				enable_q <= cfg_wdata_i[0];
			end
			if (cfg_we_i && cfg_addr_i == CFG_WATCH_TAG) begin
				watch_q <= cfg_wdata_i[FIX_TAG_W-1:0];
			end
			// a write clears, otherwise count and wrap
			if (cfg_we_i && cfg_addr_i == CFG_FIELD_CNT) begin
				field_cnt_q <= '0;
			end else if (field_valid_i) begin
				field_cnt_q <= field_cnt_q + 1'b1;
			end
			if (cfg_we_i && cfg_addr_i == CFG_MATCH_CNT) begin
				match_cnt_q <= '0;
			end else if (field_valid_i && field_i.match) begin
				match_cnt_q <= match_cnt_q + 1'b1;
			end
		end
	end

	always_comb begin
		cfg_rdata_o = '0;
		case (cfg_addr_i)
			CFG_CTRL:      cfg_rdata_o[0] = enable_q;
			CFG_WATCH_TAG: cfg_rdata_o[FIX_TAG_W-1:0] = watch_q;
			CFG_FIELD_CNT: cfg_rdata_o[FIX_CNT_W-1:0] = field_cnt_q;
			CFG_MATCH_CNT: cfg_rdata_o[FIX_CNT_W-1:0] = match_cnt_q;
			default:       cfg_rdata_o = '0;
		endcase
	end

	assign enable_o    = enable_q;
	assign watch_tag_o = watch_q;

endmodule

//--- rtl/fix_delim_detect.sv
//////////////////////////////////////////////////////////////////////
// delimiter search over one 32-bit word
// reports first SOH lane and first '=' lane in wire order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_delim_detect import fix_pkg::*; (
	input  logic [31:0] word_i,
	output fix_pos_t    soh_pos_o,
	output fix_pos_t    sep_pos_o
);

	fix_pos_t   soh_pos;
	fix_pos_t   sep_pos;
	logic [7:0] lane_b;

	// walk from lane 0 upwards so the last hit wins,
	// which is the earliest byte on the wire
	always_comb begin
		soh_pos = POS_NONE;
		sep_pos = POS_NONE;
		lane_b  = '0;
		for (int i = 0; i < 4; i++) begin
			lane_b = word_i[8*i +: 8];
			if (lane_b == FIX_SOH) begin
				soh_pos = fix_pos_t'(3'(i));
			end
			if (lane_b == FIX_SEP) begin
				sep_pos = fix_pos_t'(3'(i));
			end
		end
	end

	assign soh_pos_o = soh_pos;
	assign sep_pos_o = sep_pos;

endmodule

//--- rtl/fix_field_splitter.sv
//////////////////////////////////////////////////////////////////////
// lane classifier for the FIX parser
// splits each word into tag and value lanes, carries the tag/value
// status between words, registers the classified word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_field_splitter import fix_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        enable_i,
	input  logic [31:0] word_i,
	input  logic        word_valid_i,
	input  fix_pos_t    soh_pos_i,
	input  fix_pos_t    sep_pos_i,
	output fix_lanes_t  lanes_o,
	output logic        lanes_valid_o
);

	fix_state_t state_q;
	fix_state_t walk_state;
	logic       fresh_q;
	logic       word_take;
	logic [3:0] tag_mask;
	logic [3:0] value_mask;

	assign word_take = word_valid_i & enable_i;

	// lane walk in wire order, lane 3 first
	// a stream that was idle starts inside a tag
	always_comb begin
		walk_state = (state_q == ST_IDLE) ? ST_TAG : state_q;
		tag_mask   = '0;
		value_mask = '0;
		for (int i = 3; i >= 0; i--) begin
			if (fix_pos_t'(3'(i)) == soh_pos_i) begin
				// SOH itself is in neither mask
				walk_state = ST_TAG;
			end else if (fix_pos_t'(3'(i)) == sep_pos_i) begin
				walk_state = ST_VALUE;
			end else if (walk_state == ST_VALUE) begin
				value_mask[i] = 1'b1;
			end else begin
				tag_mask[i] = 1'b1;
			end
		end
	end

	// carried status and strobe
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q       <= ST_IDLE;
			fresh_q       <= 1'b1;
			lanes_valid_o <= 1'b0;
		end else begin
			lanes_valid_o <= word_take;
			if (!enable_i) begin
				state_q <= ST_IDLE;
				fresh_q <= 1'b1;
			end else if (word_valid_i) begin
				// whichever delimiter came later decides
				state_q <= walk_state;
				fresh_q <= 1'b0;
			end else if (state_q == ST_IDLE) begin
				state_q <= ST_TAG;
			end
		end
	end

	// classified word, loaded only on an accepted strobe
	always_ff @(posedge clk_i) begin
		if (word_take) begin
			lanes_o.data       <= word_i;
			lanes_o.tag_mask   <= tag_mask;
			lanes_o.value_mask <= value_mask;
			lanes_o.soh_pos    <= soh_pos_i;
			lanes_o.sep_pos    <= sep_pos_i;
			lanes_o.restart    <= fresh_q;
		end
	end

endmodule

//--- rtl/fix_parser_top.sv
//////////////////////////////////////////////////////////////////////
// top level of the FIX tag=value parser
// delimiter detect, lane splitter, tag decoder, register block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_parser_top import fix_pkg::*; (
	input  logic          clk_i,
	input  logic          arst_n_i,
	input  logic [31:0]   word_i,
	input  logic          word_valid_i,
	input  logic          cfg_we_i,
	input  fix_cfg_addr_t cfg_addr_i,
	input  logic [31:0]   cfg_wdata_i,
	output logic [31:0]   cfg_rdata_o,
	output fix_field_t    field_o,
	output logic          field_valid_o
);

	fix_pos_t             soh_pos;
	fix_pos_t             sep_pos;
	fix_lanes_t           lanes;
	logic                 lanes_valid;
	logic                 enable;
	logic [FIX_TAG_W-1:0] watch_tag;

	fix_delim_detect u_delim (
		.word_i    (word_i),
		.soh_pos_o (soh_pos),
		.sep_pos_o (sep_pos)
	);

	// one cycle from word strobe to classified lanes
	fix_field_splitter u_split (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.enable_i      (enable),
		.word_i        (word_i),
		.word_valid_i  (word_valid_i),
		.soh_pos_i     (soh_pos),
		.sep_pos_i     (sep_pos),
		.lanes_o       (lanes),
		.lanes_valid_o (lanes_valid)
	);

	// and one more to the field record
	fix_tag_decoder u_dec (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.lanes_i       (lanes),
		.lanes_valid_i (lanes_valid),
		.watch_tag_i   (watch_tag),
		.field_o       (field_o),
		.field_valid_o (field_valid_o)
	);

	fix_cfg_regs u_cfg (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.cfg_we_i      (cfg_we_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_wdata_i   (cfg_wdata_i),
		.cfg_rdata_o   (cfg_rdata_o),
		.field_i       (field_o),
		.field_valid_i (field_valid_o),
		.enable_o      (enable),
		.watch_tag_o   (watch_tag)
	);

endmodule

//--- rtl/fix_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions for the FIX tag=value parser
// delimiter bytes, widths, lane and state enums, word and field
// records, register addresses
//////////////////////////////////////////////////////////////////////

package fix_pkg;

	// delimiter bytes
	localparam logic [7:0] FIX_SOH = 8'h01;
	localparam logic [7:0] FIX_SEP = 8'h3d;

	localparam int FIX_TAG_W = 16;
	// value length saturates at all ones
	localparam int FIX_LEN_W = 8;
	localparam int FIX_CNT_W = 16;

	// lane numbers count from the lsb, lane 3 is first on the wire
	typedef enum logic [2:0] {
		POS_L0   = 3'd0,
		POS_L1   = 3'd1,
		POS_L2   = 3'd2,
		POS_L3   = 3'd3,
		POS_NONE = 3'b111
	} fix_pos_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_TAG,
		ST_VALUE
	} fix_state_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  tag_mask;
		logic [3:0]  value_mask;
		fix_pos_t    soh_pos;
		fix_pos_t    sep_pos;
		// first word taken after enable
		logic        restart;
	} fix_lanes_t;

	typedef struct packed {
		logic [FIX_TAG_W-1:0] tag;
		logic [FIX_LEN_W-1:0] len;
		logic [7:0]           sum;
		logic                 bad_tag;
		logic                 match;
	} fix_field_t;

	typedef enum logic [1:0] {
		CFG_CTRL,
		CFG_WATCH_TAG,
		CFG_FIELD_CNT,
		CFG_MATCH_CNT
	} fix_cfg_addr_t;

endpackage

//--- rtl/fix_tag_decoder.sv
//////////////////////////////////////////////////////////////////////
// tag decoder and field builder for the FIX parser
// ASCII tag digits to binary, value length and byte sum,
// one field record per SOH
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_tag_decoder import fix_pkg::*; (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  fix_lanes_t           lanes_i,
	input  logic                 lanes_valid_i,
	input  logic [FIX_TAG_W-1:0] watch_tag_i,
	output fix_field_t           field_o,
	output logic                 field_valid_o
);

	logic [FIX_TAG_W-1:0] tag_q;
	logic [FIX_TAG_W-1:0] tag_n;
	logic [FIX_TAG_W-1:0] digit;
	logic [FIX_LEN_W-1:0] len_q;
	logic [FIX_LEN_W-1:0] len_n;
	logic [7:0]           sum_q;
	logic [7:0]           sum_n;
	logic                 bad_q;
	logic                 bad_n;
	logic                 seen_q;
	logic                 seen_n;
	logic [7:0]           lane_b;
	logic                 emit;
	fix_field_t           rec;

	always_comb begin
		tag_n  = tag_q;
		len_n  = len_q;
		sum_n  = sum_q;
		bad_n  = bad_q;
		seen_n = seen_q;
		lane_b = '0;
		digit  = '0;
		emit   = 1'b0;
		rec    = '0;
		// partial field from before a disable is dropped
		if (lanes_i.restart) begin
			tag_n  = '0;
			len_n  = '0;
			sum_n  = '0;
			bad_n  = 1'b0;
			seen_n = 1'b0;
		end
		for (int i = 3; i >= 0; i--) begin
			lane_b = lanes_i.data[8*i +: 8];
			if (fix_pos_t'(3'(i)) == lanes_i.soh_pos) begin
				// a field without '=' gives no record
				emit        = seen_n;
				rec.tag     = tag_n;
				rec.len     = len_n;
				rec.sum     = sum_n;
				rec.bad_tag = bad_n;
				rec.match   = (tag_n == watch_tag_i) && !bad_n;
				tag_n       = '0;
				len_n       = '0;
				sum_n       = '0;
				bad_n       = 1'b0;
				seen_n      = 1'b0;
			end else if (fix_pos_t'(3'(i)) == lanes_i.sep_pos) begin
				seen_n = 1'b1;
			end else if (lanes_i.tag_mask[i]) begin
				// ASCII '0' to '9'
				if (lane_b >= 8'h30 && lane_b <= 8'h39) begin
					digit = FIX_TAG_W'(lane_b - 8'h30);
					tag_n = tag_n * FIX_TAG_W'(10) + digit;
				end else begin
					bad_n = 1'b1;
				end
			end else if (lanes_i.value_mask[i]) begin
				if (len_n != '1) begin
					len_n = len_n + 1'b1;
				end
				sum_n = sum_n + lane_b;
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tag_q         <= '0;
			len_q         <= '0;
			sum_q         <= '0;
			bad_q         <= 1'b0;
			seen_q        <= 1'b0;
			field_valid_o <= 1'b0;
		end else begin
			field_valid_o <= lanes_valid_i & emit;
			if (lanes_valid_i) begin
				tag_q  <= tag_n;
				len_q  <= len_n;
				sum_q  <= sum_n;
				bad_q  <= bad_n;
				seen_q <= seen_n;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (lanes_valid_i && emit) begin
			field_o <= rec;
		end
	end

endmodule

//--- tb.f
rtl/fix_pkg.sv
rtl/fix_delim_detect.sv
rtl/fix_field_splitter.sv
rtl/fix_tag_decoder.sv
rtl/fix_cfg_regs.sv
rtl/fix_parser_top.sv
tests/fix_parser_sva.sv
tests/fix_parser_tb.sv

//--- tests/fix_parser_sva.sv
//////////////////////////////////////////////////////////////////////
// bound assertions for the FIX parser
// field records against the expected queue head, enable gating,
// record latency, register reads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_parser_sva import fix_pkg::*; (
	input logic        clk_i,
	input logic        arst_n_i,
	input logic        word_valid_i,
	input logic        enable_i,
	input fix_pos_t    soh_pos_i,
	input logic        field_valid_i,
	input fix_field_t  field_i,
	input logic [31:0] cfg_rdata_i
);

	// every record is the oldest one the model still expects
	a_record: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_i |-> (fix_parser_tb.exp_pending != 0) && (field_i == fix_parser_tb.exp_head))
	else begin
		fix_parser_tb.rec_fail = fix_parser_tb.rec_fail + 1;
		$error("Error at %0t: field record tag %0d differs from the model", $time, field_i.tag);
	end

	// word taken two edges back needs enable set at that edge
	a_enable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_i |-> $past(enable_i, 2))
	else begin
		fix_parser_tb.en_fail = fix_parser_tb.en_fail + 1;
		$error("Error at %0t: field record while the parser was disabled", $time);
	end

	// record two edges after the strobe of the word holding its SOH
	a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_i |-> $past(word_valid_i, 2) && $past(soh_pos_i != POS_NONE, 2))
	else begin
		fix_parser_tb.tim_fail = fix_parser_tb.tim_fail + 1;
		$error("Error at %0t: field record not two edges after an SOH word", $time);
	end

	a_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		fix_parser_tb.rd_check |-> cfg_rdata_i == fix_parser_tb.exp_rdata)
	else begin
		fix_parser_tb.rd_fail = fix_parser_tb.rd_fail + 1;
		$error("Error at %0t: register read %h, expected %h", $time, cfg_rdata_i,
			fix_parser_tb.exp_rdata);
	end

endmodule

//--- tests/fix_parser_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the FIX tag=value parser
// clock and reset, register access, word stimulus, field model
// with expected record queue, watchdog, per-test reports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fix_parser_tb import fix_pkg::*; ();

	logic          clk;
	logic          arst_n;
	logic [31:0]   word;
	logic          word_valid;
	logic          cfg_we;
	fix_cfg_addr_t cfg_addr;
	logic [31:0]   cfg_wdata;
	logic [31:0]   cfg_rdata;
	fix_field_t    field;
	logic          field_valid;

	// expected records and reads for the bound assertions
	fix_field_t    exp_q[$];
	fix_field_t    exp_head;
	int            exp_pending;
	logic          rd_check;
	logic [31:0]   exp_rdata;
	int            rec_fail;
	int            en_fail;
	int            tim_fail;
	int            rd_fail;
	int            drain_fail;
	int            fail_mark;

	// field model state
	logic                 model_on;
	logic                 m_value;
	logic                 m_seen;
	logic                 m_bad;
	logic [FIX_TAG_W-1:0] m_tag;
	logic [FIX_LEN_W-1:0] m_len;
	logic [7:0]           m_sum;
	logic [FIX_TAG_W-1:0] exp_watch;
	logic [15:0]          exp_field_cnt;
	logic [15:0]          exp_match_cnt;

	integer seed;
	int     wd_cycles;
	// '|' stands for SOH on the wire
	string  s_idle     = "35=D|49=ABC|";
	string  s_aligned  = "34=1234|49=SNDR|56=TRGT|52=0930|";
	string  s_straddle = "35=D|49=ABC|56=XY|10=123|";
	string  s_bad      = "3X=1|35=A|12=BC";
	string  s_off      = "35=Z|35=Y|";
	string  s_resume   = "35=C|9=DD|";
	string  s_random;
	string  s_watch;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	fix_parser_top uut (
		.clk_i         (clk),
		.arst_n_i      (arst_n),
		.word_i        (word),
		.word_valid_i  (word_valid),
		.cfg_we_i      (cfg_we),
		.cfg_addr_i    (cfg_addr),
		.cfg_wdata_i   (cfg_wdata),
		.cfg_rdata_o   (cfg_rdata),
		.field_o       (field),
		.field_valid_o (field_valid)
	);

	bind fix_parser_top fix_parser_sva u_sva (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.word_valid_i  (word_valid_i),
		.enable_i      (enable),
		.soh_pos_i     (soh_pos),
		.field_valid_i (field_valid_o),
		.field_i       (field_o),
		.cfg_rdata_i   (cfg_rdata_o)
	);

	// retire one expected record per pulse
	always @(posedge clk) begin
		if (field_valid && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
		end
		exp_head    <= (exp_q.size() > 0) ? exp_q[0] : '0;
		exp_pending <= exp_q.size();
	end

	function automatic int padded_len(input string s);
		return (s.len() + 3) / 4 * 4;
	endfunction

	// stream padded with '7' up to a whole word
	function automatic logic [7:0] wire_byte(input string s, input int i);
		logic [7:0] c;
		c = (i < s.len()) ? s[i] : 8'h37;
		return (c == 8'h7c) ? FIX_SOH : c;
	endfunction

	function automatic int failed_checks();
		return rec_fail + en_fail + tim_fail + rd_fail + drain_fail;
	endfunction

	function automatic string random_fields(input int n, input int every);
		string s;
		string v;
		int    tag;
		int    len;
		s = "";
		for (int k = 0; k < n; k++) begin
			tag = 1 + (($random(seed) & 32'h7fffffff) % 99999);
			if (every > 0 && k % every == 0) begin
				tag = 35;
			end
			len = 1 + (($random(seed) & 32'h7fffffff) % 6);
			v = "";
			for (int j = 0; j < len; j++) begin
				v = {v, $sformatf("%c", 8'h41 + ($random(seed) & 32'h7fffffff) % 26)};
			end
			s = {s, $sformatf("%0d=%s|", tag, v)};
		end
		return s;
	endfunction

	// cuts the byte string into fields with one record per SOH after an '='
	function automatic void model_stream(input string s);
		logic [7:0] b;
		fix_field_t rec;
		for (int i = 0; model_on && i < padded_len(s); i++) begin
			b = wire_byte(s, i);
			if (b == FIX_SOH) begin
				if (m_seen) begin
					rec.tag     = m_tag;
					rec.len     = m_len;
					rec.sum     = m_sum;
					rec.bad_tag = m_bad;
					rec.match   = (m_tag == exp_watch) && !m_bad;
					exp_q.push_back(rec);
					exp_field_cnt = exp_field_cnt + 16'd1;
					exp_match_cnt = exp_match_cnt + {15'd0, rec.match};
				end
				m_value = 1'b0;
				m_seen  = 1'b0;
				m_bad   = 1'b0;
				m_tag   = '0;
				m_len   = '0;
				m_sum   = '0;
			end else if (b == FIX_SEP) begin
				m_seen  = 1'b1;
				m_value = 1'b1;
			end else if (m_value) begin
				m_len = (m_len == '1) ? m_len : m_len + 8'd1;
				m_sum = m_sum + b;
			end else if (b >= 8'h30 && b <= 8'h39) begin
				m_tag = m_tag * 16'd10 + 16'(b - 8'h30);
			end else begin
				m_bad = 1'b1;
			end
		end
	endfunction

	task automatic write_reg(input fix_cfg_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		cfg_we    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic read_check(input fix_cfg_addr_t addr, input logic [31:0] expv);
		@(posedge clk);
		cfg_addr  <= addr;
		exp_rdata <= expv;
		rd_check  <= 1'b1;
		@(posedge clk);
		rd_check <= 1'b0;
	endtask

	task automatic check_regs();
		read_check(CFG_CTRL, {31'd0, model_on});
		read_check(CFG_WATCH_TAG, {16'd0, exp_watch});
		read_check(CFG_FIELD_CNT, {16'd0, exp_field_cnt});
		read_check(CFG_MATCH_CNT, {16'd0, exp_match_cnt});
	endtask

	// a fresh enable drops any partial field
	task automatic set_enable(input logic en);
		write_reg(CFG_CTRL, {31'd0, en});
		model_on = en;
		m_value  = 1'b0;
		m_seen   = 1'b0;
		m_bad    = 1'b0;
		m_tag    = '0;
		m_len    = '0;
		m_sum    = '0;
	endtask

	task automatic send_stream(input string s, input int gap_max);
		int gap;
		for (int i = 0; i < padded_len(s); i += 4) begin
			gap = ($random(seed) & 32'h7fffffff) % (gap_max + 1);
			repeat (gap) begin
				@(posedge clk);
				word_valid <= 1'b0;
			end
			@(posedge clk);
			word <= {wire_byte(s, i), wire_byte(s, i + 1), wire_byte(s, i + 2),
				wire_byte(s, i + 3)};
			word_valid <= 1'b1;
		end
		@(posedge clk);
		word_valid <= 1'b0;
	endtask

	task automatic run_stream(input string s, input int gap_max);
		int n;
		model_stream(s);
		send_stream(s, gap_max);
		n = 0;
		while (exp_q.size() != 0 && n < 64) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected field records never came out of the DUT", exp_q.size());
			drain_fail++;
			exp_q.delete();
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic report(input int num, input string name);
		$display("test %0d %s: %0d failed checks", num, name, failed_checks() - fail_mark);
		fail_mark = failed_checks();
	endtask

	initial begin
		seed          = 13778;
		arst_n        = 1'b0;
		word          = '0;
		word_valid    = 1'b0;
		cfg_we        = 1'b0;
		cfg_addr      = CFG_CTRL;
		cfg_wdata     = '0;
		rd_check      = 1'b0;
		exp_rdata     = '0;
		model_on      = 1'b0;
		exp_watch     = '0;
		exp_field_cnt = '0;
		exp_match_cnt = '0;
		fail_mark     = 0;
		s_random      = random_fields(40, 0);
		s_watch       = random_fields(24, 3);
		// four cycles per word plus margin for register traffic
		wd_cycles = padded_len(s_idle) + padded_len(s_aligned) + padded_len(s_straddle)
			+ padded_len(s_bad) + padded_len(s_off) + padded_len(s_resume)
			+ padded_len(s_random) + padded_len(s_watch) + 1500;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		run_stream(s_idle, 2);
		check_regs();
		report(1, "disabled after reset");

		set_enable(1'b1);
		run_stream(s_aligned, 2);
		check_regs();
		report(2, "aligned fields");

		set_enable(1'b0);
		set_enable(1'b1);
		run_stream(s_straddle, 2);
		check_regs();
		report(3, "fields across words");

		set_enable(1'b0);
		set_enable(1'b1);
		run_stream(s_random, 1);
		check_regs();
		report(4, "back-to-back words");

		write_reg(CFG_FIELD_CNT, 32'd0);
		write_reg(CFG_MATCH_CNT, 32'd0);
		write_reg(CFG_WATCH_TAG, 32'd35);
		exp_field_cnt = '0;
		exp_match_cnt = '0;
		exp_watch     = 16'd35;
		set_enable(1'b0);
		set_enable(1'b1);
		check_regs();
		run_stream(s_watch, 2);
		check_regs();
		write_reg(CFG_FIELD_CNT, 32'd0);
		exp_field_cnt = '0;
		check_regs();
		// match count is nonzero here after the watched tags
		write_reg(CFG_MATCH_CNT, 32'd0);
		exp_match_cnt = '0;
		check_regs();
		report(5, "watched tag and counters");

		// partial field "12=BC" is lost when enable drops
		set_enable(1'b0);
		set_enable(1'b1);
		run_stream(s_bad, 1);
		set_enable(1'b0);
		run_stream(s_off, 0);
		check_regs();
		set_enable(1'b1);
		run_stream(s_resume, 1);
		check_regs();
		report(6, "bad tag and enable toggle");

		$display("tests run: 6, failed checks: %0d", failed_checks());
		if (failed_checks() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("run timed out after %0d clock cycles without finishing", wd_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
